// File: all.f
+incdir+verification
src/RasterPixelPkg.sv
src/RasterConfPkg.sv
src/FragmentReceiver.sv
src/TestFunc.sv
src/ColorBlender.sv
src/FramebufferPipeline.sv
src/FramebufferMemory.sv
src/PixelBackend.sv
verification/PixelBackendTb.sv

// File: src/ColorBlender.sv
////////////////////////////////////////
// Two-stage source/destination blend, saturated per channel
////////////////////////////////////////
`timescale 1ns/1ps

module ColorBlender
    import RasterPixelPkg::*;
    import RasterConfPkg::*;
(
    input  logic         aclk,
    input  blendFactor_t srcFactor,
    input  blendFactor_t dstFactor,
    input  pixel_t       sourceColor,
    input  pixel_t       destColor,
    output pixel_t       color
);

    // Alpha onto 0..256, 255 lands exactly on one
    function automatic logic [8:0] alphaScale(input logic [7:0] alpha);
        alphaScale = {1'b0, alpha} + {8'd0, alpha[7]};
    endfunction

    function automatic logic [8:0] selectFactor(
        input blendFactor_t f,
        input logic [8:0]   srcA,
        input logic [8:0]   dstA
    );
        case (f)
            ONE:                 selectFactor = 9'd256;
            SRC_ALPHA:           selectFactor = srcA;
            ONE_MINUS_SRC_ALPHA: selectFactor = 9'd256 - srcA;
            DST_ALPHA:           selectFactor = dstA;
            ONE_MINUS_DST_ALPHA: selectFactor = 9'd256 - dstA;
            default:             selectFactor = 9'd0;
        endcase
    endfunction

    logic [8:0]  srcScale;
    logic [8:0]  dstScale;
    logic [31:0] srcWord;
    logic [31:0] dstWord;
    // 255 * 256 still fits in 16 bits
    logic [15:0] srcProd [4];
    logic [15:0] dstProd [4];
    logic [31:0] satWord;

    assign srcScale = selectFactor(srcFactor, alphaScale(sourceColor.a), alphaScale(destColor.a));
    assign dstScale = selectFactor(dstFactor, alphaScale(sourceColor.a), alphaScale(destColor.a));
    assign srcWord  = sourceColor;
    assign dstWord  = destColor;

    ////////////////////////////////////////
    // Stage one, channel products
    ////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            srcProd[i] <= srcWord[i*8 +: 8] * srcScale;
            dstProd[i] <= dstWord[i*8 +: 8] * dstScale;
        end
    end

    ////////////////////////////////////////
    // Stage two, sum, shift and saturate
    ////////////////////////////////////////
    always_comb
    begin
        logic [16:0] sum;
        for (int i = 0; i < 4; i++)
        begin
            sum = {1'b0, srcProd[i]} + {1'b0, dstProd[i]};
            // Carry into bit 16 means the result went past 255
            satWord[i*8 +: 8] = sum[16] ? 8'hff : sum[15:8];
        end
    end

    always_ff @(posedge aclk)
    begin
        color <= satWord;
    end

endmodule

// File: src/FragmentReceiver.sv
////////////////////////////////////////
// Four-phase fragment intake, issues into the pipeline
// and stalls any fragment whose index is still in flight
////////////////////////////////////////
`timescale 1ns/1ps

module FragmentReceiver
    import RasterPixelPkg::*;
#(
    parameter int FbIndexWidth = 8,
    parameter int PipeDepth    = 5
)
(
    input  logic                    aclk,
    input  logic                    rst,
    // High once the buffers are cleared
    input  logic                    enable,

    input  logic                    fragReq,
    input  fragment_t               fragment,
    output logic                    fragAck,

    output logic                    issueValid,
    output fragment_t               issueFrag,

    input  logic                    retireValid,
    input  logic [FbIndexWidth-1:0] retireIndex
);

    localparam int SlotWidth = (PipeDepth > 1) ? $clog2(PipeDepth) : 1;

    // Scoreboard, one slot per fragment in the pipeline
    logic [PipeDepth-1:0]    slotValid;
    logic [FbIndexWidth-1:0] slotIndex [PipeDepth];
    logic [PipeDepth-1:0]    slotHit;
    logic [SlotWidth-1:0]    freeSlot;
    logic                    accept;

    // Match against every slot, lowest free slot wins
    always_comb
    begin
        freeSlot = '0;
        for (int i = PipeDepth - 1; i >= 0; i--)
        begin
            slotHit[i] = slotValid[i] && (slotIndex[i] == fragment.index);
            if (!slotValid[i])
                freeSlot = SlotWidth'(i);
        end
    end

    // Issue only without hazard and with a free slot
    assign accept = fragReq && !fragAck && enable && !(|slotHit) && !(&slotValid);

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            fragAck    <= 1'b0;
            issueValid <= 1'b0;
            slotValid  <= '0;
        end
        else
        begin
            issueValid <= accept;

            // Ack rises with the issue, falls once the source lets go
            if (accept)
                fragAck <= 1'b1;
            else if (!fragReq)
                fragAck <= 1'b0;

            // Retired index leaves the scoreboard
            for (int i = 0; i < PipeDepth; i++)
            begin
                if (retireValid && slotValid[i] && (slotIndex[i] == retireIndex))
                    slotValid[i] <= 1'b0;
            end

            // Never the retiring slot, that one is still occupied
            if (accept)
                slotValid[freeSlot] <= 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (accept)
        begin
            issueFrag           <= fragment;
            slotIndex[freeSlot] <= fragment.index;
        end
    end

endmodule

// File: src/FramebufferMemory.sv
////////////////////////////////////////
// Colour and depth buffers with pipeline read and write ports,
// a four-phase scan-out port and a clear walk after reset
////////////////////////////////////////
`timescale 1ns/1ps

module FramebufferMemory
    import RasterPixelPkg::*;
#(
    parameter int FbIndexWidth = 8
)
(
    input  logic                    aclk,
    input  logic                    rst,

    input  logic [FbIndexWidth-1:0] readIndex,
    output pixel_t                  colorIn,
    output depth_t                  depthIn,

    input  logic                    colorWe,
    input  logic                    depthWe,
    input  logic [FbIndexWidth-1:0] writeIndex,
    input  pixel_t                  colorOut,
    input  depth_t                  depthOut,

    input  logic                    scanReq,
    input  logic [FbIndexWidth-1:0] scanIndex,
    output logic                    scanAck,
    output pixel_t                  scanColor,
    output depth_t                  scanDepth,

    // Low while the clear walk runs
    output logic                    cleared
);

    localparam int Entries = 2 ** FbIndexWidth;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_READ,
        SCAN_HOLD
    } scanState_t;

    pixel_t                  colorMem [Entries];
    depth_t                  depthMem [Entries];
    logic [FbIndexWidth-1:0] readAddr;
    logic [FbIndexWidth-1:0] clearAddr;
    logic [FbIndexWidth-1:0] scanAddr;
    scanState_t              scanState;

    ////////////////////////////////////////
    // Clear walk and write port
    ////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            clearAddr <= '0;
            cleared   <= 1'b0;
        end
        else if (!cleared)
        begin
            clearAddr <= clearAddr + 1'b1;
            if (&clearAddr)
                cleared <= 1'b1;
        end
    end

    // Writes land on the edge that samples the enable
    always_ff @(posedge aclk)
    begin
        if (!cleared)
        begin
            colorMem[clearAddr] <= '0;
            depthMem[clearAddr] <= '1;
        end
        else
        begin
            if (colorWe)
                colorMem[writeIndex] <= colorOut;
            if (depthWe)
                depthMem[writeIndex] <= depthOut;
        end
    end

    ////////////////////////////////////////
    // Read ports, address and data registered
    ////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        readAddr <= readIndex;
        colorIn  <= colorMem[readAddr];
        depthIn  <= depthMem[readAddr];

        // Scan address taken while idle, data frozen while acked
        if (scanState == SCAN_IDLE)
            scanAddr <= scanIndex;
        if (scanState == SCAN_READ)
        begin
            scanColor <= colorMem[scanAddr];
            scanDepth <= depthMem[scanAddr];
        end
    end

    // Scan-out four-phase slave
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            scanState <= SCAN_IDLE;
            scanAck   <= 1'b0;
        end
        else
        begin
            case (scanState)
                SCAN_IDLE:
                    if (scanReq && cleared)
                        scanState <= SCAN_READ;
                SCAN_READ:
                begin
                    scanAck   <= 1'b1;
                    scanState <= SCAN_HOLD;
                end
                default:
                    if (!scanReq)
                    begin
                        scanAck   <= 1'b0;
                        scanState <= SCAN_IDLE;
                    end
            endcase
        end
    end

endmodule

// File: src/FramebufferPipeline.sv
////////////////////////////////////////
// Five-cycle back end: buffer read, depth clamp, alpha and
// depth tests, blend and write back of one fragment per cycle
////////////////////////////////////////
`timescale 1ns/1ps

module FramebufferPipeline
    import RasterPixelPkg::*;
    import RasterConfPkg::*;
#(
    parameter int FbIndexWidth = 8,
    // Issue to write enable, the stage layout below assumes 5
    parameter int PipeDepth    = 5
)
(
    input  logic                    aclk,
    input  logic                    rst,
    input  rasterConf_t             conf,

    input  logic                    issueValid,
    input  fragment_t               issueFrag,

    // Buffer read, data two cycles after the index
    output logic [FbIndexWidth-1:0] readIndex,
    input  pixel_t                  colorIn,
    input  depth_t                  depthIn,

    // Buffer write
    output logic                    colorWe,
    output logic                    depthWe,
    output logic [FbIndexWidth-1:0] writeIndex,
    output pixel_t                  colorOut,
    output depth_t                  depthOut,

    output logic                    retireValid,
    output logic [FbIndexWidth-1:0] retireIndex
);

    localparam int ReadLatency = 2;
    localparam int LastStage   = PipeDepth - 2;

    typedef struct packed {
        depth_t                  depth;
        logic [FbIndexWidth-1:0] index;
    } stage_t;

    // Entry n holds the fragment n+1 cycles after issue
    logic [PipeDepth-2:0] validSr;
    stage_t               stageSr [PipeDepth-1];
    pixel_t               colorSr [ReadLatency];

    logic                 alphaPass;
    logic                 depthPass;
    logic                 writeOk;
    pixel_t               blendColor;

    // Negative goes to 0, 1.0 and above to all ones
    function automatic depth_t clampDepth(input logic [FRAG_DEPTH_WIDTH-1:0] z);
        if (z[FRAG_DEPTH_WIDTH-1])
            clampDepth = '0;
        else if (|z[FRAG_DEPTH_WIDTH-2:DEPTH_WIDTH])
            clampDepth = '1;
        else
            clampDepth = z[DEPTH_WIDTH-1:0];
    endfunction

    ////////////////////////////////////////
    // Read and delay line
    ////////////////////////////////////////
    assign readIndex = issueFrag.index;

    always_ff @(posedge aclk)
    begin
        if (rst)
            validSr <= '0;
        else
            validSr <= {validSr[PipeDepth-3:0], issueValid};
    end

    always_ff @(posedge aclk)
    begin
        stageSr[0].depth <= clampDepth(issueFrag.depth);
        stageSr[0].index <= issueFrag.index;
        for (int i = 1; i < PipeDepth - 1; i++)
            stageSr[i] <= stageSr[i-1];

        // Source colour is only needed until the blender takes it
        colorSr[0] <= issueFrag.color;
        for (int i = 1; i < ReadLatency; i++)
            colorSr[i] <= colorSr[i-1];
    end

    ////////////////////////////////////////
    // Tests and blend, buffer data arrives here
    ////////////////////////////////////////
    TestFunc #(
        .Width(8)
    ) alphaTest (
        .aclk(aclk),
        .func(conf.alphaFunc),
        .refVal(conf.alphaRef),
        .val(colorSr[ReadLatency-1].a),
        .success(alphaPass)
    );

    TestFunc #(
        .Width(DEPTH_WIDTH)
    ) depthTest (
        .aclk(aclk),
        .func(conf.depthFunc),
        .refVal(depthIn),
        .val(stageSr[ReadLatency-1].depth),
        .success(depthPass)
    );

    ColorBlender colorBlender (
        .aclk(aclk),
        .srcFactor(conf.srcFactor),
        .dstFactor(conf.dstFactor),
        .sourceColor(colorSr[ReadLatency-1]),
        .destColor(colorIn),
        .color(blendColor)
    );

    // Test results line up with the blender output
    always_ff @(posedge aclk)
    begin
        writeOk <= alphaPass && (!conf.depthEnable || depthPass);
    end

    ////////////////////////////////////////
    // Write back
    ////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            colorWe     <= 1'b0;
            depthWe     <= 1'b0;
            retireValid <= 1'b0;
        end
        else
        begin
            colorWe     <= validSr[LastStage] && writeOk;
            depthWe     <= validSr[LastStage] && writeOk && conf.depthEnable;
            // Rejected fragments retire as well
            retireValid <= validSr[LastStage];
        end
    end

    always_ff @(posedge aclk)
    begin
        writeIndex <= stageSr[LastStage].index;
        colorOut   <= blendColor;
        depthOut   <= stageSr[LastStage].depth;
    end

    assign retireIndex = writeIndex;

endmodule

// File: src/PixelBackend.sv
////////////////////////////////////////
// Fragment back end top level
// Receiver, pipeline and on-chip buffers
////////////////////////////////////////
`timescale 1ns/1ps

module PixelBackend
    import RasterPixelPkg::*;
    import RasterConfPkg::*;
#(
    // Has to match FB_INDEX_WIDTH of the fragment type
    parameter int FbIndexWidth = FB_INDEX_WIDTH,
    parameter int PipeDepth    = 5
)
(
    input  logic                    aclk,
    input  logic                    rst,
    input  rasterConf_t             conf,

    input  logic                    fragReq,
    input  fragment_t               fragment,
    output logic                    fragAck,

    input  logic                    scanReq,
    input  logic [FbIndexWidth-1:0] scanIndex,
    output logic                    scanAck,
    output pixel_t                  scanColor,
    output depth_t                  scanDepth
);

    logic                    issueValid;
    fragment_t               issueFrag;
    logic                    retireValid;
    logic [FbIndexWidth-1:0] retireIndex;
    logic [FbIndexWidth-1:0] readIndex;
    pixel_t                  colorIn;
    depth_t                  depthIn;
    logic                    colorWe;
    logic                    depthWe;
    logic [FbIndexWidth-1:0] writeIndex;
    pixel_t                  colorOut;
    depth_t                  depthOut;
    logic                    cleared;

    // No fragment is taken before the clear walk finishes
    FragmentReceiver #(
        .FbIndexWidth(FbIndexWidth),
        .PipeDepth(PipeDepth)
    ) fragmentReceiver (
        .aclk(aclk),
        .rst(rst),
        .enable(cleared),
        .fragReq(fragReq),
        .fragment(fragment),
        .fragAck(fragAck),
        .issueValid(issueValid),
        .issueFrag(issueFrag),
        .retireValid(retireValid),
        .retireIndex(retireIndex)
    );

    FramebufferPipeline #(
        .FbIndexWidth(FbIndexWidth),
        .PipeDepth(PipeDepth)
    ) framebufferPipeline (
        .aclk(aclk),
        .rst(rst),
        .conf(conf),
        .issueValid(issueValid),
        .issueFrag(issueFrag),
        .readIndex(readIndex),
        .colorIn(colorIn),
        .depthIn(depthIn),
        .colorWe(colorWe),
        .depthWe(depthWe),
        .writeIndex(writeIndex),
        .colorOut(colorOut),
        .depthOut(depthOut),
        .retireValid(retireValid),
        .retireIndex(retireIndex)
    );

    FramebufferMemory #(
        .FbIndexWidth(FbIndexWidth)
    ) framebufferMemory (
        .aclk(aclk),
        .rst(rst),
        .readIndex(readIndex),
        .colorIn(colorIn),
        .depthIn(depthIn),
        .colorWe(colorWe),
        .depthWe(depthWe),
        .writeIndex(writeIndex),
        .colorOut(colorOut),
        .depthOut(depthOut),
        .scanReq(scanReq),
        .scanIndex(scanIndex),
        .scanAck(scanAck),
        .scanColor(scanColor),
        .scanDepth(scanDepth),
        .cleared(cleared)
    );

endmodule

// File: src/RasterConfPkg.sv
////////////////////////////////////////
// Test function and blend factor encodings, plus the
// configuration word that stays stable while fragments fly
////////////////////////////////////////
package RasterConfPkg;

    // Comparison applied as "fragment value FUNC reference"
    typedef enum logic [2:0] {
        NEVER,
        ALWAYS,
        LESS,
        EQUAL,
        LEQUAL,
        GREATER,
        NOTEQUAL,
        GEQUAL
    } testFunc_t;

    // Blend factors, evaluated on a 0..256 scale
    // Codes 6 and 7 are unused and act as ZERO
    typedef enum logic [2:0] {
        ZERO,
        ONE,
        SRC_ALPHA,
        ONE_MINUS_SRC_ALPHA,
        DST_ALPHA,
        ONE_MINUS_DST_ALPHA
    } blendFactor_t;

    // Complete back end state
    typedef struct packed {
        testFunc_t    alphaFunc;
        logic [7:0]   alphaRef;
        logic         depthEnable;
        testFunc_t    depthFunc;
        blendFactor_t srcFactor;
        blendFactor_t dstFactor;
    } rasterConf_t;

endpackage

// File: src/RasterPixelPkg.sv
////////////////////////////////////////
// Pixel, depth and fragment types of the back end data path
// Imported by wildcard into the modules that carry fragments
////////////////////////////////////////
package RasterPixelPkg;

    // Index width fixed into the fragment type
    // The top level FbIndexWidth has to equal this value
    localparam int FB_INDEX_WIDTH = 8;

    // Stored depth precision
    localparam int DEPTH_WIDTH = 16;

    // Incoming fixed point depth
    // Bit 31 is the sign, 1.0 sits at bit 16
    localparam int FRAG_DEPTH_WIDTH = 32;

    typedef logic [DEPTH_WIDTH-1:0] depth_t;

    // One RGBA colour, red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [7:0] a;
    } pixel_t;

    // Shaded fragment as it arrives from the rasterizer
    typedef struct packed {
        pixel_t                      color;
        logic [FRAG_DEPTH_WIDTH-1:0] depth;
        logic [FB_INDEX_WIDTH-1:0]   index;
    } fragment_t;

endpackage

// File: src/TestFunc.sv
////////////////////////////////////////
// Registered compare for alpha and depth tests
////////////////////////////////////////
`timescale 1ns/1ps

module TestFunc
    import RasterConfPkg::*;
#(
    parameter int Width = 8
)
(
    input  logic             aclk,
    input  testFunc_t        func,
    input  logic [Width-1:0] refVal,
    input  logic [Width-1:0] val,
    output logic             success
);

    // One cycle latency
    // val is the fragment side, refVal the stored or configured side
    always_ff @(posedge aclk)
    begin
        case (func)
            ALWAYS:
                success <= 1'b1;
            LESS:
                success <= val < refVal;
            EQUAL:
                success <= val == refVal;
            LEQUAL:
                success <= val <= refVal;
            GREATER:
                success <= val > refVal;
            NOTEQUAL:
                success <= val != refVal;
            GEQUAL:
                success <= val >= refVal;
            default:
                success <= 1'b0;
        endcase
    end

endmodule

// File: verification/PixelBackendModel.svh
////////////////////////////////////////
// Reference model of the colour and depth buffers, included into the testbench
// Fragments are applied in acceptance order
////////////////////////////////////////

// Model buffers, same reset contents as the DUT
pixel_t modelColor [2**FB_INDEX_WIDTH];
depth_t modelDepth [2**FB_INDEX_WIDTH];

task automatic modelReset();
    for (int i = 0; i < 2**FB_INDEX_WIDTH; i++)
    begin
        modelColor[i] = '0;
        modelDepth[i] = '1;
    end
endtask

// Negative to 0, 1.0 or more to all ones
function automatic depth_t clampModel(input logic [31:0] z);
    if ($signed(z) < 0)
        return '0;
    if (z >= 32'h0001_0000)
        return '1;
    return z[15:0];
endfunction

// Fragment value compared against the reference
function automatic logic compareModel(input testFunc_t f, input int val, input int refv);
    case (f)
        ALWAYS:   return 1'b1;
        LESS:     return val < refv;
        EQUAL:    return val == refv;
        LEQUAL:   return val <= refv;
        GREATER:  return val > refv;
        NOTEQUAL: return val != refv;
        GEQUAL:   return val >= refv;
        default:  return 1'b0;
    endcase
endfunction

// Factor on a 0..256 scale, alpha a becomes a plus its top bit
function automatic int factorModel(input blendFactor_t f, input int srcA, input int dstA);
    int sa;
    int da;
    sa = srcA + srcA / 128;
    da = dstA + dstA / 128;
    case (f)
        ONE:                 return 256;
        SRC_ALPHA:           return sa;
        ONE_MINUS_SRC_ALPHA: return 256 - sa;
        DST_ALPHA:           return da;
        ONE_MINUS_DST_ALPHA: return 256 - da;
        default:             return 0;
    endcase
endfunction

function automatic logic [7:0] blendChannel(input int s, input int d, input int sf, input int df);
    int sum;
    sum = (s * sf + d * df) / 256;
    return (sum > 255) ? 8'd255 : sum[7:0];
endfunction

function automatic pixel_t blendModel(input pixel_t src, input pixel_t dst, input rasterConf_t c);
    pixel_t result;
    int sf;
    int df;
    sf = factorModel(c.srcFactor, src.a, dst.a);
    df = factorModel(c.dstFactor, src.a, dst.a);
    result.r = blendChannel(src.r, dst.r, sf, df);
    result.g = blendChannel(src.g, dst.g, sf, df);
    result.b = blendChannel(src.b, dst.b, sf, df);
    result.a = blendChannel(src.a, dst.a, sf, df);
    return result;
endfunction

// One accepted fragment against the model buffers
task automatic modelApply(input fragment_t f, input rasterConf_t c);
    depth_t z;
    logic   alphaOk;
    logic   depthOk;
    z       = clampModel(f.depth);
    alphaOk = compareModel(c.alphaFunc, f.color.a, c.alphaRef);
    depthOk = !c.depthEnable || compareModel(c.depthFunc, z, modelDepth[f.index]);
    if (alphaOk && depthOk)
    begin
        modelColor[f.index] = blendModel(f.color, modelColor[f.index], c);
        if (c.depthEnable)
            modelDepth[f.index] = z;
    end
endtask

// File: verification/PixelBackendTb.sv
////////////////////////////////////////
// Testbench of the fragment back end, random fragments from an LFSR
// checked through scan-out against the included model
////////////////////////////////////////
`timescale 1ns/1ps

module PixelBackendTb
    import RasterPixelPkg::*;
    import RasterConfPkg::*;
();

    // Run length, one scan per fragment plus the reset scans
    localparam int FragTotal      = 216;
    localparam int ScanTotal      = 232;
    // Reset, clear walk and slack
    localparam int SetupCycles    = 400;
    localparam int CycleLimit     = FragTotal * 40 + ScanTotal * 10 + SetupCycles;
    localparam int HandshakeLimit = 300;
    // Ack to stored result is at most 6 cycles
    localparam int DrainCycles    = 8;

    logic                      aclk = 1'b0;
    logic                      rst;
    rasterConf_t               conf;
    logic                      fragReq;
    fragment_t                 fragment;
    logic                      fragAck;
    logic                      scanReq;
    logic [FB_INDEX_WIDTH-1:0] scanIndex;
    logic                      scanAck;
    pixel_t                    scanColor;
    depth_t                    scanDepth;

    logic [31:0]               lfsr;
    int                        cycleCount = 0;
    string                     testName;
    int                        testErrors;
    int                        errorCount  = 0;
    int                        checkCount  = 0;
    int                        testCount   = 0;
    int                        testsFailed = 0;
    logic                      reqSeen     = 1'b0;
    logic                      idleAck     = 1'b0;
    logic [FB_INDEX_WIDTH-1:0] touched [$];

    `include "PixelBackendModel.svh"

    PixelBackend #(
        .FbIndexWidth(FB_INDEX_WIDTH),
        .PipeDepth(5)
    ) PixelBackend_i (
        .aclk(aclk),
        .rst(rst),
        .conf(conf),
        .fragReq(fragReq),
        .fragment(fragment),
        .fragAck(fragAck),
        .scanReq(scanReq),
        .scanIndex(scanIndex),
        .scanAck(scanAck),
        .scanColor(scanColor),
        .scanDepth(scanDepth)
    );

    always #4 aclk = ~aclk;

    // Global run limit
    always @(posedge aclk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit)
        begin
            $display("Run did not finish within %0d cycles", CycleLimit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // fragAck must not rise before any request was made
    always @(negedge aclk)
    begin
        if (!rst && fragAck && !reqSeen)
            idleAck = 1'b1;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    // Mix of negative, in-range and 1.0-or-more depths
    function automatic logic [31:0] randDepth();
        logic [1:0]  kind;
        logic [31:0] raw;
        kind = randBits(2);
        raw  = randBits(32);
        case (kind)
            2'd0:    return {1'b1, raw[30:0]};
            2'd1:    return {1'b0, raw[30:16] | 15'h1, raw[15:0]};
            default: return {16'h0, raw[15:0]};
        endcase
    endfunction

    task automatic recordError();
        errorCount++;
        testErrors++;
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
        touched.delete();
    endtask

    task automatic finishTest();
        testCount++;
        if (testErrors != 0)
            testsFailed++;
        $display("Test %s finished with %0d errors", testName, testErrors);
    endtask

    // Only called with the pipeline empty
    task automatic applyConf(input logic [2:0] af, input logic [7:0] ar, input logic de,
                             input logic [2:0] df, input logic [2:0] sf, input logic [2:0] bf);
        conf.alphaFunc   = testFunc_t'(af);
        conf.alphaRef    = ar;
        conf.depthEnable = de;
        conf.depthFunc   = testFunc_t'(df);
        conf.srcFactor   = blendFactor_t'(sf);
        conf.dstFactor   = blendFactor_t'(bf);
    endtask

    // Four-phase fragment send, starts and ends on a falling edge
    task automatic sendFragment(input fragment_t f, input int holdCycles);
        int waited;
        fragment = f;
        fragReq  = 1'b1;
        reqSeen  = 1'b1;
        waited   = 0;
        while (!fragAck && waited < HandshakeLimit)
        begin
            @(negedge aclk);
            waited++;
        end
        if (!fragAck)
        begin
            $display("%s: fragment to index %0d was never acknowledged", testName, f.index);
            recordError();
        end
        else
            modelApply(f, conf);
        // Source may hold the request a while before dropping it
        repeat (holdCycles) @(negedge aclk);
        fragReq = 1'b0;
        waited  = 0;
        while (fragAck && waited < HandshakeLimit)
        begin
            @(negedge aclk);
            waited++;
        end
        if (fragAck)
        begin
            $display("%s: fragAck stayed high after the request dropped", testName);
            recordError();
        end
    endtask

    task automatic sendRandom(input logic [FB_INDEX_WIDTH-1:0] base, input int indexBits,
                              input int holdBits);
        fragment_t f;
        f.color = randBits(32);
        f.depth = randDepth();
        f.index = base | randBits(indexBits);
        touched.push_back(f.index);
        sendFragment(f, randBits(holdBits));
    endtask

    // Scan one index and compare with the model
    task automatic scanCheck(input logic [FB_INDEX_WIDTH-1:0] idx);
        int waited;
        scanIndex = idx;
        scanReq   = 1'b1;
        waited    = 0;
        while (!scanAck && waited < HandshakeLimit)
        begin
            @(negedge aclk);
            waited++;
        end
        if (!scanAck)
        begin
            $display("%s: scan of index %0d was never acknowledged", testName, idx);
            recordError();
        end
        else
        begin
            checkCount++;
            if (scanColor !== modelColor[idx])
            begin
                $display("** Error %s: index %0d colour expected %h actual %h",
                         testName, idx, modelColor[idx], scanColor);
                recordError();
            end
            if (scanDepth !== modelDepth[idx])
            begin
                $display("** Error %s: index %0d depth expected %h actual %h",
                         testName, idx, modelDepth[idx], scanDepth);
                recordError();
            end
        end
        scanReq = 1'b0;
        waited  = 0;
        while (scanAck && waited < HandshakeLimit)
        begin
            @(negedge aclk);
            waited++;
        end
        if (scanAck)
        begin
            $display("%s: scanAck stayed high after the request dropped", testName);
            recordError();
        end
    endtask

    task automatic waitDrain();
        repeat (DrainCycles) @(negedge aclk);
    endtask

    // Let the last fragments land, then read back every touched index
    task automatic scanTouched();
        waitDrain();
        foreach (touched[i])
            scanCheck(touched[i]);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial
    begin
        lfsr      = 32'h449c;
        rst       = 1'b1;
        conf      = '0;
        fragReq   = 1'b0;
        fragment  = '0;
        scanReq   = 1'b0;
        scanIndex = '0;
        modelReset();
        repeat (10) @(negedge aclk);
        rst = 1'b0;

        // Reset clear, scans wait for the clear walk
        startTest("reset_clear");
        if (fragAck || scanAck)
        begin
            $display("%s: handshake outputs were not low after reset", testName);
            recordError();
        end
        for (int i = 0; i < 16; i++)
            scanCheck(randBits(FB_INDEX_WIDTH));
        if (idleAck)
        begin
            $display("%s: fragAck rose without a request", testName);
            recordError();
        end
        finishTest();

        // Plain write, depth off
        startTest("plain_write");
        applyConf(ALWAYS, 8'd0, 1'b0, ALWAYS, ONE, ZERO);
        for (int i = 0; i < 40; i++)
            sendRandom('0, FB_INDEX_WIDTH, 0);
        scanTouched();
        finishTest();

        // Depth LESS over 16 indices, clamp at both ends
        startTest("depth_clamp");
        applyConf(ALWAYS, 8'd0, 1'b1, LESS, ONE, ZERO);
        for (int i = 0; i < 40; i++)
            sendRandom(8'h40, 4, 0);
        scanTouched();
        finishTest();

        // Alpha test, new function and reference per round
        startTest("alpha_test");
        for (int r = 0; r < 4; r++)
        begin
            applyConf(randBits(3), randBits(8), 1'b1, ALWAYS, ONE, ZERO);
            for (int i = 0; i < 10; i++)
                sendRandom(8'h60, 4, 0);
            waitDrain();
        end
        scanTouched();
        finishTest();

        // Prefill, then random factor pairs
        startTest("blending");
        applyConf(ALWAYS, 8'd0, 1'b0, ALWAYS, ONE, ZERO);
        for (int i = 0; i < 16; i++)
            sendRandom(8'h80 + i, 0, 0);
        waitDrain();
        for (int r = 0; r < 4; r++)
        begin
            applyConf(ALWAYS, 8'd0, 1'b0, ALWAYS, randBits(3), randBits(3));
            for (int i = 0; i < 10; i++)
                sendRandom(8'h80, 4, 0);
            waitDrain();
        end
        scanTouched();
        finishTest();

        // Four indices, random hold before the request drops
        startTest("hazard_backpressure");
        applyConf(ALWAYS, 8'd0, 1'b1, LEQUAL, SRC_ALPHA, ONE_MINUS_SRC_ALPHA);
        for (int i = 0; i < 40; i++)
            sendRandom(8'hC0, 2, 2);
        scanTouched();
        finishTest();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testCount, testsFailed, checkCount, errorCount);
        if (errorCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
